// ==== hw/memL1Pkg.sv ====
// Types shared by the caches, the arbiter and the memory port
// Addresses are byte addresses and only aligned 64-bit words are handled
// Memory moves whole 16-byte lines on reads and single words on writes
`default_nettype none

package memL1Pkg;

	typedef logic [31:0]  addrT;	// Byte address
	typedef logic [63:0]  wordT;	// Instruction or data word
	typedef logic [127:0] lineT;	// Cache line and memory beat

	typedef enum logic [1:0] {
		opmReady     = 2'd0,	// Port idle
		opmReadLine  = 2'd1,	// Read one 16-byte line
		opmWriteWord = 2'd2	// Write one 64-bit word
	} memOpmT;

	typedef enum logic [1:0] {
		okReady = 2'd0,	// Nothing pending
		okDone  = 2'd1,	// Request complete this cycle
		okHold  = 2'd2	// Busy, keep inputs stable
	} memOkT;

	typedef enum logic [1:0] {
		dcNone  = 2'd0,	// No data access
		dcLoad  = 2'd1,	// Aligned word load
		dcStore = 2'd2	// Aligned word store
	} dcOpmT;

	typedef struct packed {
		memOpmT opm;	// Operation toward memory
		addrT   addr;	// Line or word address
		wordT   data;	// Store word, writes only
	} memReqT;

	typedef struct packed {
		memOkT ok;	// Memory status
		lineT  line;	// Read data, valid with okDone
	} memRspT;

endpackage

`default_nettype wire

// ==== hw/instCache.sv ====
// Direct-mapped read-only instruction cache with 16-byte lines
// Fetch address bits [2:0] are ignored, fetches are 8-byte aligned
// A hit answers okDone one cycle after the fetch is taken
// A miss holds until the line is refilled, then answers from the array
// The core must keep addr stable while ok reads okHold
// numLines must be a power of two and at least 2
`timescale 1ns/1ps
`default_nettype none

module instCache
	import memL1Pkg::*;
#(
	parameter int numLines = 64
)
(
	input  wire         clock,
	input  wire         rstN,
	input  wire addrT   addr,
	output wordT        val,
	output memOkT       ok,
	output memReqT      memReqOut,
	input  wire memRspT memRspIn
);

	localparam int idxW = $clog2(numLines);
	localparam int tagW = 32 - 4 - idxW;

	typedef enum logic {
		icIdle,	// Serving hits
		icFill	// Line read outstanding
	} icStateT;

	icStateT             state;
	logic                fetchValid;	// A fetch has been taken
	addrT                reqAddr;	// Registered fetch address
	logic [tagW-1:0]     tagArr [numLines];
	lineT                lineArr [numLines];
	logic [numLines-1:0] validArr;

	logic [idxW-1:0] reqIdx;
	logic [tagW-1:0] reqTag;
	lineT            curLine;
	logic            hit;
	logic            accept;
	logic            fillDone;

	assign reqIdx   = reqAddr[4 +: idxW];	// Line index
	assign reqTag   = reqAddr[31 -: tagW];	// Upper bits
	assign curLine  = lineArr[reqIdx];
	assign hit      = validArr[reqIdx] && (tagArr[reqIdx] == reqTag);
	assign fillDone = (state == icFill) && (memRspIn.ok == okDone);
	assign accept   = (ok != okHold);	// Take a new fetch
	assign val      = reqAddr[3] ? curLine[127:64] : curLine[63:0];	// Half select

	always_comb
	begin
		if (!fetchValid)
			ok = okReady;	// Nothing fetched yet
		else if ((state == icIdle) && hit)
			ok = okDone;	// Hit, or replay after fill
		else
			ok = okHold;	// Miss detected or filling
	end

	always_comb
	begin
		memReqOut.opm  = (state == icFill) ? opmReadLine : opmReady;
		memReqOut.addr = {reqAddr[31:4], 4'h0};	// Line aligned
		memReqOut.data = '0;	// Never writes
	end

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			state      <= icIdle;
			fetchValid <= 1'b0;
			validArr   <= '0;	// Cache empty
		end
		else
		begin
			if (accept)
				fetchValid <= 1'b1;
			case (state)
				icIdle:
					if (fetchValid && !hit)
						state <= icFill;	// Start line read
				icFill:
					if (fillDone)
					begin
						state            <= icIdle;	// Replay the fetch
						validArr[reqIdx] <= 1'b1;
					end
				default:
					state <= icIdle;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (accept)
			reqAddr <= addr;
		if (fillDone)
		begin
			tagArr[reqIdx]  <= reqTag;
			lineArr[reqIdx] <= memRspIn.line;	// Returned line
		end
	end

endmodule

`default_nettype wire

// ==== hw/dataCache.sv ====
// Direct-mapped write-through data cache with 16-byte lines
// Only aligned 64-bit loads and stores, address bits [2:0] are ignored
// A load hit answers okDone one cycle after the request is taken
// Every store goes to memory, a store miss does not allocate a line
// The core must keep addr, opm and wrVal stable while ok reads okHold
// numLines must be a power of two and at least 2
`timescale 1ns/1ps
`default_nettype none

module dataCache
	import memL1Pkg::*;
#(
	parameter int numLines = 64
)
(
	input  wire         clock,
	input  wire         rstN,
	input  wire addrT   addr,
	input  wire dcOpmT  opm,
	input  wire wordT   wrVal,
	output wordT        val,
	output memOkT       ok,
	output memReqT      memReqOut,
	input  wire memRspT memRspIn
);

	localparam int idxW = $clog2(numLines);
	localparam int tagW = 32 - 4 - idxW;

	typedef enum logic [1:0] {
		dsIdle,	// Serving hits
		dsFill,	// Load miss, line read outstanding
		dsWrite	// Store word outstanding
	} dsStateT;

	dsStateT             state;
	dcOpmT               reqOpm;	// Registered operation
	logic                wrDone;	// Store for reqAddr finished
	addrT                reqAddr;
	wordT                reqWrVal;
	logic [tagW-1:0]     tagArr [numLines];
	lineT                lineArr [numLines];
	logic [numLines-1:0] validArr;

	logic [idxW-1:0] reqIdx;
	logic [tagW-1:0] reqTag;
	lineT            curLine;
	logic            hit;
	logic            accept;
	logic            memDone;

	assign reqIdx  = reqAddr[4 +: idxW];
	assign reqTag  = reqAddr[31 -: tagW];
	assign curLine = lineArr[reqIdx];
	assign hit     = validArr[reqIdx] && (tagArr[reqIdx] == reqTag);
	assign memDone = (memRspIn.ok == okDone);
	assign accept  = (ok != okHold);
	assign val     = reqAddr[3] ? curLine[127:64] : curLine[63:0];

	always_comb
	begin
		ok = okHold;	// Fill and write states
		if (state == dsIdle)
		begin
			case (reqOpm)
				dcLoad:  ok = hit ? okDone : okHold;
				dcStore: ok = wrDone ? okDone : okHold;
				default: ok = okReady;	// No access pending
			endcase
		end
	end

	always_comb
	begin
		memReqOut.opm  = opmReady;
		memReqOut.addr = {reqAddr[31:3], 3'h0};	// Word aligned
		memReqOut.data = reqWrVal;
		if (state == dsFill)
		begin
			memReqOut.opm  = opmReadLine;
			memReqOut.addr = {reqAddr[31:4], 4'h0};	// Line aligned
		end
		else if (state == dsWrite)
			memReqOut.opm = opmWriteWord;
	end

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			state    <= dsIdle;
			reqOpm   <= dcNone;
			wrDone   <= 1'b0;
			validArr <= '0;
		end
		else
		begin
			if (accept)
			begin
				reqOpm <= opm;
				wrDone <= 1'b0;	// New request pending
			end
			case (state)
				dsIdle:
					if ((reqOpm == dcLoad) && !hit)
						state <= dsFill;
					else if ((reqOpm == dcStore) && !wrDone)
						state <= dsWrite;
				dsFill:
					if (memDone)
					begin
						state            <= dsIdle;	// Replay as a hit
						validArr[reqIdx] <= 1'b1;
					end
				dsWrite:
					if (memDone)
					begin
						state  <= dsIdle;
						wrDone <= 1'b1;	// Report okDone next
					end
				default:
					state <= dsIdle;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			reqAddr  <= addr;
			reqWrVal <= wrVal;
		end
		if ((state == dsFill) && memDone)
		begin
			tagArr[reqIdx]  <= reqTag;
			lineArr[reqIdx] <= memRspIn.line;
		end
		else if ((state == dsWrite) && memDone && hit)
		begin
			if (reqAddr[3])
				lineArr[reqIdx][127:64] <= reqWrVal;	// Upper half hit
			else
				lineArr[reqIdx][63:0] <= reqWrVal;
		end
	end

endmodule

`default_nettype wire

// ==== hw/memArbiter.sv ====
// Shares the single memory port between the instruction and data caches
// Request to memory is combinational, one registered grant per side
// Instruction side wins when both ask while no grant is held
// A grant lasts until the cycle memory answers okDone
// Requesters must drop opm to opmReady the cycle after okDone
`timescale 1ns/1ps
`default_nettype none

module memArbiter
	import memL1Pkg::*;
(
	input  wire         clock,
	input  wire         rstN,
	input  wire memReqT icReq,
	input  wire memReqT dcReq,
	output memRspT      icRsp,
	output memRspT      dcRsp,
	output memReqT      memReq,
	input  wire memRspT memRsp
);

	logic grantIc;	// Port held by instruction side
	logic grantDc;	// Port held by data side
	logic icBusy;
	logic dcBusy;
	logic selIc;
	logic selDc;
	logic doneNow;

	assign icBusy  = (icReq.opm != opmReady);
	assign dcBusy  = (dcReq.opm != opmReady);
	assign selIc   = grantIc || (icBusy && !grantDc);	// Priority when idle
	assign selDc   = !selIc && (grantDc || dcBusy);
	assign doneNow = (memRsp.ok == okDone);

	always_comb
	begin
		memReq.opm  = opmReady;	// Idle port
		memReq.addr = '0;
		memReq.data = '0;
		icRsp.ok    = icBusy ? okHold : okReady;	// Loser waits
		icRsp.line  = memRsp.line;
		dcRsp.ok    = dcBusy ? okHold : okReady;
		dcRsp.line  = memRsp.line;
		if (selIc)
		begin
			memReq = icReq;
			icRsp  = memRsp;	// Pass status straight back
		end
		else if (selDc)
		begin
			memReq = dcReq;
			dcRsp  = memRsp;
		end
	end

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			grantIc <= 1'b0;
			grantDc <= 1'b0;
		end
		else
		begin
			grantIc <= selIc && icBusy && !doneNow;	// Release after okDone
			grantDc <= selDc && dcBusy && !doneNow;
		end
	end

endmodule

`default_nettype wire

// ==== hw/memL1.sv ====
// Level-one memory subsystem, instruction and data caches on one memory port
// Both caches are direct-mapped with numLines lines of 16 bytes
// Memory must follow the okHold then single okDone handshake
`timescale 1ns/1ps
`default_nettype none

module memL1
	import memL1Pkg::*;
#(
	parameter int numLines = 64
)
(
	input  wire         clock,
	input  wire         rstN,
	input  wire addrT   icAddr,
	output wordT        icVal,
	output memOkT       icOk,
	input  wire addrT   dcAddr,
	input  wire dcOpmT  dcOpm,
	input  wire wordT   dcWrVal,
	output wordT        dcVal,
	output memOkT       dcOk,
	output memReqT      memReq,
	input  wire memRspT memRsp
);

	memReqT icReq;	// Instruction miss port
	memReqT dcReq;	// Data miss and store port
	memRspT icRsp;
	memRspT dcRsp;

	instCache #(
		.numLines(numLines)
	) i_instCache (
		.clock    (clock),
		.rstN     (rstN),
		.addr     (icAddr),
		.val      (icVal),
		.ok       (icOk),
		.memReqOut(icReq),
		.memRspIn (icRsp)
	);

	dataCache #(
		.numLines(numLines)
	) i_dataCache (
		.clock    (clock),
		.rstN     (rstN),
		.addr     (dcAddr),
		.opm      (dcOpm),
		.wrVal    (dcWrVal),
		.val      (dcVal),
		.ok       (dcOk),
		.memReqOut(dcReq),
		.memRspIn (dcRsp)
	);

	memArbiter i_memArbiter (
		.clock (clock),
		.rstN  (rstN),
		.icReq (icReq),
		.dcReq (dcReq),
		.icRsp (icRsp),
		.dcRsp (dcRsp),
		.memReq(memReq),
		.memRsp(memRsp)
	);

endmodule

`default_nettype wire

// ==== testbench/memL1Checker.sv ====
// Scoreboard for the core-side ports of memL1, sampled on the falling edge
// Expected words are the address pattern overlaid by every store the core issues
// Fetches must never touch addresses that are stored to, the caches are not coherent
`timescale 1ns/1ps
`default_nettype none

module memL1Checker
	import memL1Pkg::*;
(
	input  wire         clock,
	input  wire         rstN,
	input  wire [79:0]  testName,
	input  wire addrT   icAddr,
	input  wire wordT   icVal,
	input  wire memOkT  icOk,
	input  wire addrT   dcAddr,
	input  wire dcOpmT  dcOpm,
	input  wire wordT   dcWrVal,
	input  wire wordT   dcVal,
	input  wire memOkT  dcOk,
	output logic [31:0] checkCount,
	output logic [31:0] mismatchCount
);

	wordT        shadow [logic [28:0]];	// Stored words by word address
	addrT        icPend;	// Fetch answered by the next okDone
	addrT        dcPend;
	dcOpmT       dcPendOp = dcNone;
	int unsigned checks = 0;
	int unsigned mismatches = 0;

	assign checkCount    = checks;
	assign mismatchCount = mismatches;

	function automatic wordT patternWord(input addrT a);
		addrT w;
		w = {a[31:3], 3'b000};	// Word aligned
		return {w ^ 32'h9e37_79b9, {w[15:0], w[31:16]} ^ 32'h5bd1_e995};
	endfunction

	function automatic wordT refWord(input addrT a);
		if (shadow.exists(a[31:3]))
			return shadow[a[31:3]];	// Last store wins
		return patternWord(a);
	endfunction

	task automatic compareWord(input string side, input addrT a, input wordT got);
		wordT expected;
		expected = refWord(a);
		checks = checks + 1;
		if (got !== expected)
		begin
			mismatches = mismatches + 1;
			$display("mismatch test %0s %0s addr %h expected %h actual %h",
				testName, side, a, expected, got);
		end
	endtask

	always @(negedge clock)
	begin
		if (rstN)
		begin
			if (icOk == okDone)
				compareWord("fetch", icPend, icVal);
			if ((dcOk == okDone) && (dcPendOp == dcLoad))
				compareWord("load", dcPend, dcVal);
			if (icOk != okHold)
				icPend = icAddr;	// Taken at the next rising edge
			if (dcOk != okHold)
			begin
				dcPendOp = dcOpm;
				dcPend   = dcAddr;
				if (dcOpm == dcStore)
					shadow[dcAddr[31:3]] = dcWrVal;	// Visible to later loads
			end
		end
	end

endmodule

`default_nettype wire

// ==== testbench/memL1_assertions.sv ====
// Memory port protocol checks, bound into every memArbiter instance
// Assumes memRsp changes only after the rising clock edge
`timescale 1ns/1ps
`default_nettype none

module memL1Assertions
	import memL1Pkg::*;
(
	input wire         clock,
	input wire         rstN,
	input wire         grantIc,
	input wire         grantDc,
	input wire memReqT memReq,
	input wire memRspT memRsp
);

	int unsigned failCount = 0;	// Failed assertions so far

	grantsExclusive: assert property (@(posedge clock) disable iff (!rstN)
		!(grantIc && grantDc))
	else
	begin
		failCount = failCount + 1;
		$error("instruction and data grants are both set");
	end

	reqStableOnHold: assert property (@(posedge clock) disable iff (!rstN)
		(memRsp.ok == okHold) |=> $stable(memReq))
	else
	begin
		failCount = failCount + 1;
		$error("memory request changed while memory answered hold");
	end

	doneSingleCycle: assert property (@(posedge clock) disable iff (!rstN)
		(memRsp.ok == okDone) |=> (memRsp.ok != okDone))
	else
	begin
		failCount = failCount + 1;
		$error("memory done status lasted more than one cycle");
	end

	idleAfterReset: assert property (@(posedge clock)
		$rose(rstN) |-> (memReq.opm == opmReady))
	else
	begin
		failCount = failCount + 1;
		$error("memory request not idle after reset");
	end

endmodule

bind memArbiter memL1Assertions i_arbAssertions (
	.clock  (clock),
	.rstN   (rstN),
	.grantIc(grantIc),
	.grantDc(grantDc),
	.memReq (memReq),
	.memRsp (memRsp)
);

`default_nettype wire

// ==== testbench/memL1Tb.sv ====
// Testbench for the level-one memory subsystem
// Backing memory answers after 1 to 4 okHold cycles, latency from an LCG
// Fetches use a low region and data accesses a high one, never stored by fetch
// Conflict addresses assume numLines lines of 16 bytes per cache
`timescale 1ns/1ps
`default_nettype none

module memL1Tb
	import memL1Pkg::*;
();

	localparam int   clkPeriod    = 4;
	localparam int   numLines     = 64;
	localparam int   stride       = numLines * 16;	// Same index, next tag
	localparam addrT icBase       = 32'h0000_1000;
	localparam addrT dcBase       = 32'h0004_0000;
	localparam int   numRandLoads = 24;
	localparam int   numConflict  = 16;
	localparam int   numMixed     = 300;
	localparam int   numRequests  = 2 + numRandLoads + 7 + 2 + 2 * numConflict + 2 * numMixed;

	logic        clock;
	logic        rstN;
	addrT        icAddr;
	addrT        dcAddr;
	dcOpmT       dcOpm;
	wordT        dcWrVal;
	wordT        icVal;
	wordT        dcVal;
	memOkT       icOk;
	memOkT       dcOk;
	memReqT      memReq;
	memRspT      memRsp;
	logic [79:0] testName;	// Ten characters, space padded
	logic [31:0] checkCount;
	logic [31:0] mismatchCount;
	int unsigned otherErrors;
	logic [31:0] stimSeed;
	logic [31:0] latSeed;
	lineT        memArr [logic [27:0]];	// Backing memory by line address

	memL1 #(
		.numLines(numLines)
	) i_dut (
		.clock  (clock),
		.rstN   (rstN),
		.icAddr (icAddr),
		.icVal  (icVal),
		.icOk   (icOk),
		.dcAddr (dcAddr),
		.dcOpm  (dcOpm),
		.dcWrVal(dcWrVal),
		.dcVal  (dcVal),
		.dcOk   (dcOk),
		.memReq (memReq),
		.memRsp (memRsp)
	);

	memL1Checker i_checker (
		.clock        (clock),
		.rstN         (rstN),
		.testName     (testName),
		.icAddr       (icAddr),
		.icVal        (icVal),
		.icOk         (icOk),
		.dcAddr       (dcAddr),
		.dcOpm        (dcOpm),
		.dcWrVal      (dcWrVal),
		.dcVal        (dcVal),
		.dcOk         (dcOk),
		.checkCount   (checkCount),
		.mismatchCount(mismatchCount)
	);

	function automatic logic [31:0] lcgStep(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic wordT fillWord(input addrT a);
		addrT w;
		w = {a[31:3], 3'b000};
		return {w ^ 32'h9e37_79b9, {w[15:0], w[31:16]} ^ 32'h5bd1_e995};
	endfunction

	task automatic step();
		@(posedge clock);
		#1;	// Drive point
	endtask

	task automatic serveMemory(input memReqT r);
		logic [27:0] key;
		lineT        cur;
		key = r.addr[31:4];
		if (!memArr.exists(key))
			memArr[key] = {fillWord({key, 4'h8}), fillWord({key, 4'h0})};	// First touch
		cur = memArr[key];
		if (r.opm == opmWriteWord)
		begin
			if (r.addr[3])
				cur[127:64] = r.data;
			else
				cur[63:0] = r.data;
			memArr[key] = cur;
		end
		else
			memRsp.line = cur;
	endtask

	task automatic startFetch(input addrT a);
		while (icOk == okHold)
			step();	// Inputs frozen while holding
		icAddr = a;
	endtask

	task automatic startData(input dcOpmT op, input addrT a, input wordT v);
		while (dcOk == okHold)
			step();
		dcOpm   = op;
		dcAddr  = a;
		dcWrVal = v;
	endtask

	task automatic waitDone(output int cycles);
		logic busy;
		cycles = 0;
		busy   = 1'b1;
		while (busy)
		begin
			step();
			cycles = cycles + 1;
			if (dcOk != okHold)
				dcOpm = dcNone;	// Do not repeat the access
			busy = (icOk == okHold) || (dcOk == okHold);
		end
	endtask

	initial
	begin
		clock = 1'b0;
		forever #(clkPeriod / 2) clock = ~clock;
	end

	// Backing memory, one request at a time
	initial
	begin
		memReqT     curReq;
		logic [1:0] holdLeft;
		logic       busy;
		memRsp   = '0;	// okReady
		busy     = 1'b0;
		holdLeft = 2'd0;
		forever
		begin
			step();
			if (!rstN)
			begin
				busy      = 1'b0;
				memRsp.ok = okReady;
			end
			else if (busy)
			begin
				if (holdLeft != 2'd0)
					holdLeft = holdLeft - 2'd1;
				else
				begin
					serveMemory(curReq);
					memRsp.ok = okDone;	// Single cycle
					busy      = 1'b0;
				end
			end
			else if (memReq.opm != opmReady)
			begin
				latSeed   = lcgStep(latSeed);
				holdLeft  = latSeed[17:16];	// 1 to 4 hold cycles
				curReq    = memReq;
				busy      = 1'b1;
				memRsp.ok = okHold;
			end
			else
				memRsp.ok = okReady;
		end
	end

	initial
	begin
		repeat (numRequests * 20 + 20) @(posedge clock);
		$display("timeout: the tests did not finish within %0d requests of 20 cycles", numRequests);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial
	begin
		int          cycles;
		int          k;
		addrT        a;
		addrT        ia;
		addrT        da;
		logic [31:0] r2;
		int unsigned assertFails;
		rstN        = 1'b0;
		icAddr      = icBase;
		dcAddr      = dcBase;
		dcOpm       = dcNone;
		dcWrVal     = '0;
		stimSeed    = 32'hae4e;
		latSeed     = 32'hae4e;
		otherErrors = 0;
		testName    = "reset     ";
		repeat (5) @(posedge clock);
		#1;
		rstN = 1'b1;
		if ((icOk != okReady) || (dcOk != okReady))
		begin
			otherErrors = otherErrors + 1;
			$display("error: cache status was not ready right after reset");
		end

		testName = "fetchHit  ";	// Miss, then the same word hits
		startFetch(icBase + 32'h40);
		waitDone(cycles);
		startFetch(icBase + 32'h40);
		waitDone(cycles);
		if (cycles != 1)
		begin
			otherErrors = otherErrors + 1;
			$display("error: a fetch hit took %0d cycles instead of 1", cycles);
		end

		testName = "loadRand  ";
		for (k = 0; k < numRandLoads; k++)
		begin
			stimSeed = lcgStep(stimSeed);
			a = dcBase + {17'd0, stimSeed[27:16], 3'b000};
			startData(dcLoad, a, '0);
			waitDone(cycles);
		end

		testName = "storeLoad ";
		a = dcBase + 32'h1_0000;	// Line not cached
		startData(dcStore, a, 64'h0123_4567_89ab_cdef);
		waitDone(cycles);
		startData(dcLoad, a, '0);
		waitDone(cycles);
		a = a + 32'h100;	// Cached before the store
		startData(dcLoad, a, '0);
		waitDone(cycles);
		startData(dcStore, a, 64'hfeed_f00d_0bad_cafe);
		waitDone(cycles);
		startData(dcLoad, a, '0);
		waitDone(cycles);
		startData(dcStore, a + 32'h8, 64'h1122_3344_5566_7788);	// Upper half
		waitDone(cycles);
		startData(dcLoad, a + 32'h8, '0);
		waitDone(cycles);

		testName = "dualMiss  ";	// Both misses taken on one edge
		startFetch(icBase + 32'h3000);
		startData(dcLoad, dcBase + 32'h2_0000, '0);
		waitDone(cycles);

		testName = "conflict  ";
		for (k = 0; k < numConflict; k++)
		begin
			ia = icBase + 32'h4008 + ((k % 2 == 1) ? stride : 0);
			da = dcBase + 32'h3_0008 + ((k % 2 == 1) ? stride : 0);
			startFetch(ia);
			if (k == 6)
				startData(dcStore, da, {32'hc0f1_1c70, k});
			else
				startData(dcLoad, da, '0);
			waitDone(cycles);
		end

		testName = "mixed     ";
		for (k = 0; k < numMixed; k++)
		begin
			stimSeed = lcgStep(stimSeed);
			r2 = lcgStep(stimSeed);
			ia = icBase + (stimSeed[20] ? stride : 0) + {25'd0, stimSeed[19:16], 3'b000};
			da = dcBase + (r2[20] ? stride : 0) + {25'd0, r2[19:16], 3'b000};
			if (stimSeed[31:30] != 2'd1)
				startFetch(ia);	// Fetch only or both
			if (stimSeed[31:30] != 2'd0)
				startData(r2[31] ? dcStore : dcLoad, da, {r2, stimSeed});
			waitDone(cycles);
			stimSeed = r2;
		end

		repeat (4) step();
		if (checkCount == 0)
		begin
			otherErrors = otherErrors + 1;
			$display("error: no fetch or load response was ever checked");
		end
		assertFails = i_dut.i_memArbiter.i_arbAssertions.failCount;
		$display("checks %0d, mismatches %0d, other errors %0d, assertion failures %0d",
			checkCount, mismatchCount, otherErrors, assertFails);
		if ((mismatchCount == 0) && (otherErrors == 0) && (assertFails == 0))
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
hw/memL1Pkg.sv
hw/instCache.sv
hw/dataCache.sv
hw/memArbiter.sv
hw/memL1.sv
testbench/memL1Checker.sv
testbench/memL1_assertions.sv
testbench/memL1Tb.sv

// ==== Makefile ====
# Verilator build and run of the memL1 testbench

VERILATOR ?= verilator
TOP       ?= memL1Tb
FILELIST  ?= tb.f
BUILD_DIR ?= build
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
